// ==== rv_core.f ====
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_pc_unit.sv
rv_core.sv
rv_core_asserts.sv
rv_core_tb.sv

// ==== Makefile ====
TOP := rv_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f rv_core.f -o $(TOP)

# the error limit lets the testbench see a bound assertion failure and end with $fatal
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

// ==== rv_core_tb.sv ====
`include "rv_core_params.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int prog_len = 200;
  localparam int max_cycles = 250;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [`RV_XLEN-1:0]   insn;
  logic [`RV_XLEN-1:0]   pc;
  logic                  halt;
  logic                  rf_we;
  logic [`RV_REG_AW-1:0] rf_rd;
  logic [`RV_XLEN-1:0]   rf_wdata;
  logic [31:0]           prog [prog_len];
  logic [31:0]           shadow [`RV_NREGS];
  logic [31:0]           model_pc;
  int                    cycles = 0;
  int                    halt_cycles;

  always #4 clk = ~clk;

  rv_core rv_core_inst (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_insn     (insn),
    .o_pc       (pc),
    .o_halt     (halt),
    .o_rf_we    (rf_we),
    .o_rf_rd    (rf_rd),
    .o_rf_wdata (rf_wdata)
  );

  // instruction memory read combinationally by pc
  always_comb begin
    if (pc < 32'(prog_len * 4)) begin
      insn = prog[pc[9:2]];
    end else begin
      insn = '0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: core did not halt within %0d cycles", max_cycles);
      $display("Testbench failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      // logical shift, then the vacated upper bits filled with the sign for sra
      3'b101:  return (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{alt & a[31]}});
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] off;
    logic [2:0]  br_codes [6];
    int          kind;
    int          hop;
    br_codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (int i = 0; i < prog_len - 1; i++) begin
      // a small register window keeps dependencies and x0 frequent
      rd   = 5'($urandom_range(7));
      rs1  = 5'($urandom_range(7));
      rs2  = 5'($urandom_range(7));
      f3   = 3'($urandom_range(7));
      imm  = 12'($urandom);
      kind = $urandom_range(9);
      if (kind < 2) begin
        prog[i] = {20'($urandom), rd, rv_isa_pkg::OP_LUI};
      end else if (kind < 5) begin
        if (f3 == 3'b001) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'b101) begin
          imm = {($urandom_range(1) != 0) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE, imm[4:0]};
        end
        prog[i] = {imm, rs1, f3, rd, rv_isa_pkg::OP_IMM};
      end else if (kind < 8) begin
        f7 = rv_isa_pkg::F7_BASE;
        if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) != 0) begin
          f7 = rv_isa_pkg::F7_ALT;
        end
        prog[i] = {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
      end else begin
        // forward offsets that never pass the final ecall
        hop = $urandom_range(6, 1);
        if (i + hop > prog_len - 1) begin
          hop = prog_len - 1 - i;
        end
        off = 13'(hop * 4);
        f3  = br_codes[3'($urandom_range(5))];
        prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
      end
    end
    prog[prog_len - 1] = {25'b0, rv_isa_pkg::OP_SYSTEM};
  endtask

  task automatic expect_write(input logic [4:0] rd, input logic [31:0] value);
    assert (rf_we && rf_rd == rd)
      else report_error($sformatf("write port we=%b rd=%0d, expected we=1 rd=%0d",
                                  rf_we, rf_rd, rd));
    assert (rf_wdata == value)
      else report_error($sformatf("x%0d write data %h, expected %h", rd, rf_wdata, value));
    // x0 is never updated in the model
    if (rd != 5'd0) begin
      shadow[rd] = value;
    end
  endtask

  task automatic check_and_step();
    logic [31:0] ins;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] next_pc;
    logic        taken;
    ins     = prog[model_pc[9:2]];
    f3      = ins[14:12];
    alt     = (ins[31:25] == rv_isa_pkg::F7_ALT);
    a       = shadow[ins[19:15]];
    b       = shadow[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    next_pc = model_pc + 32'd4;
    assert (!rv_core_inst.rv_core_asserts_inst.any_fail)
      else report_error("a bound assertion in rv_core failed");
    assert (pc == model_pc)
      else report_error($sformatf("pc is %h, expected %h", pc, model_pc));
    case (ins[6:0])
      rv_isa_pkg::OP_LUI: expect_write(ins[11:7], {ins[31:12], 12'h000});
      rv_isa_pkg::OP_IMM: expect_write(ins[11:7], alu_ref(f3, alt && f3 == 3'b101, a, imm_i));
      rv_isa_pkg::OP_REG: expect_write(ins[11:7], alu_ref(f3, alt, a, b));
      rv_isa_pkg::OP_BRANCH: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) begin
          next_pc = model_pc + imm_b;
        end
      end
      default: begin
        // only ecall is left in the program
        assert (halt)
          else report_error("ecall did not raise o_halt");
        next_pc = model_pc;
        halt_cycles++;
      end
    endcase
    model_pc = next_pc;
  endtask

  initial begin
    rst         = 1'b1;
    model_pc    = `RV_XLEN'(`RV_RESET_PC);
    halt_cycles = 0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      shadow[i] = '0;
    end
    void'($urandom(32'h6c55_63ef));
    build_program();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    // outputs are settled at the falling edge
    while (halt_cycles < 3) begin
      @(negedge clk);
      check_and_step();
    end
    if (!rv_core_inst.rv_core_asserts_inst.any_fail) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_error("a bound assertion in rv_core failed");
    end
  end

endmodule

// ==== rv_core_asserts.sv ====
`include "rv_core_params.svh"

module rv_core_asserts (
  input logic                i_clk,
  input logic                i_rst,
  input logic [`RV_XLEN-1:0] i_insn,
  input logic [`RV_XLEN-1:0] i_pc,
  input logic [`RV_XLEN-1:0] i_rs1_data,
  input logic [`RV_XLEN-1:0] i_rs2_data,
  input logic                i_halt,
  input logic                i_rf_we
);
  timeunit 1ns;
  timeprecision 1ps;

  logic                is_branch;
  logic                is_ecall;
  logic [`RV_XLEN-1:0] b_off;
  logic                br_cond;
  logic [`RV_XLEN-1:0] br_next;
  logic                fail_rst_we = 1'b0;
  logic                fail_rst_pc = 1'b0;
  logic                fail_br_we = 1'b0;
  logic                fail_br_pc = 1'b0;
  logic                fail_ecall = 1'b0;
  logic                fail_hold = 1'b0;
  logic                any_fail;

  assign is_branch = (i_insn[6:0] == rv_isa_pkg::OP_BRANCH);
  assign is_ecall  = (i_insn == {25'b0, rv_isa_pkg::OP_SYSTEM});
  assign b_off     = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};

  // expected branch outcome straight from the register read data
  always_comb begin
    case (i_insn[14:12])
      3'b000:  br_cond = (i_rs1_data == i_rs2_data);
      3'b001:  br_cond = (i_rs1_data != i_rs2_data);
      3'b100:  br_cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      3'b101:  br_cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      3'b110:  br_cond = (i_rs1_data < i_rs2_data);
      3'b111:  br_cond = (i_rs1_data >= i_rs2_data);
      default: br_cond = 1'b0;
    endcase
  end

  assign br_next  = i_pc + (br_cond ? b_off : `RV_XLEN'(`RV_PC_STEP));
  assign any_fail = |{fail_rst_we, fail_rst_pc, fail_br_we, fail_br_pc, fail_ecall, fail_hold};

  a_rst_no_write: assert property (@(posedge i_clk) i_rst |-> !i_rf_we)
    else begin
      fail_rst_we = 1'b1;
      $error("register write while in reset");
    end

  // covers the reset cycles and the first cycle after reset
  a_rst_pc: assert property (@(posedge i_clk) i_rst |=> (i_pc == `RV_XLEN'(`RV_RESET_PC)))
    else begin
      fail_rst_pc = 1'b1;
      $error("pc is not the reset value after a reset cycle");
    end

  a_br_no_write: assert property (@(posedge i_clk) (!i_rst && is_branch) |-> !i_rf_we)
    else begin
      fail_br_we = 1'b1;
      $error("branch wrote the register file");
    end

  a_br_target: assert property (@(posedge i_clk)
      (!i_rst && is_branch) |=> (i_pc == $past(br_next)))
    else begin
      fail_br_pc = 1'b1;
      $error("wrong pc after a branch");
    end

  a_ecall_halt: assert property (@(posedge i_clk)
      (!i_rst && is_ecall) |-> (i_halt && !i_rf_we))
    else begin
      fail_ecall = 1'b1;
      $error("ecall did not halt cleanly");
    end

  // a halted core keeps the same pc, stays halted and never writes
  a_halt_hold: assert property (@(posedge i_clk)
      (!i_rst && i_halt) |=> ($stable(i_pc) && i_halt && !i_rf_we))
    else begin
      fail_hold = 1'b1;
      $error("core left the halt state");
    end

endmodule

bind rv_core rv_core_asserts rv_core_asserts_inst (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_insn     (i_insn),
  .i_pc       (o_pc),
  .i_rs1_data (rs1_data),
  .i_rs2_data (rs2_data),
  .i_halt     (o_halt),
  .i_rf_we    (o_rf_we)
);

// ==== rv_core.sv ====
`include "rv_core_params.svh"

module rv_core (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [`RV_XLEN-1:0]   i_insn,
  output logic [`RV_XLEN-1:0]   o_pc,
  output logic                  o_halt,
  output logic                  o_rf_we,
  output logic [`RV_REG_AW-1:0] o_rf_rd,
  output logic [`RV_XLEN-1:0]   o_rf_wdata
);

  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   imm;
  rv_ctrl_pkg::alu_op_e  alu_op;
  rv_ctrl_pkg::opb_sel_e opb_sel;
  rv_ctrl_pkg::wb_sel_e  wb_sel;
  logic                  dec_we;
  logic                  branch;
  rv_isa_pkg::br_f3_e    br_f3;
  logic                  halt;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   opb;
  logic [`RV_XLEN-1:0]   alu_result;
  logic                  eq;
  logic                  lt;
  logic                  ltu;

  rv_decoder rv_decoder_inst (
    .i_insn    (i_insn),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (rd),
    .o_imm     (imm),
    .o_alu_op  (alu_op),
    .o_opb_sel (opb_sel),
    .o_wb_sel  (wb_sel),
    .o_rf_we   (dec_we),
    .o_branch  (branch),
    .o_br_f3   (br_f3),
    .o_halt    (halt)
  );

  // no register writes while halted or held in reset
  assign o_rf_we    = dec_we && !halt && !i_rst;
  assign o_rf_rd    = rd;
  assign o_rf_wdata = (wb_sel == rv_ctrl_pkg::WB_UIMM) ? imm : alu_result;
  assign o_halt     = halt;

  rv_regfile rv_regfile_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (o_rf_we),
    .i_wdata    (o_rf_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign opb = (opb_sel == rv_ctrl_pkg::OPB_IMM) ? imm : rs2_data;

  rv_alu rv_alu_inst (
    .i_a      (rs1_data),
    .i_b      (opb),
    .i_op     (alu_op),
    .o_result (alu_result),
    .o_eq     (eq),
    .o_lt     (lt),
    .o_ltu    (ltu)
  );

  // imm holds the b-type offset whenever branch is set
  rv_pc_unit rv_pc_unit_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_branch    (branch),
    .i_br_f3     (br_f3),
    .i_eq        (eq),
    .i_lt        (lt),
    .i_ltu       (ltu),
    .i_halt      (halt),
    .i_br_offset (imm),
    .o_pc        (o_pc)
  );

endmodule

// ==== rv_pc_unit.sv ====
`include "rv_core_params.svh"

module rv_pc_unit (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_branch,
  input  rv_isa_pkg::br_f3_e  i_br_f3,
  input  logic                i_eq,
  input  logic                i_lt,
  input  logic                i_ltu,
  input  logic                i_halt,
  input  logic [`RV_XLEN-1:0] i_br_offset,
  output logic [`RV_XLEN-1:0] o_pc
);

  logic                cond;
  logic                taken;
  logic [`RV_XLEN-1:0] pc_inc;

  // branch condition from the alu flags
  always_comb begin
    case (i_br_f3)
      rv_isa_pkg::BEQ:  cond = i_eq;
      rv_isa_pkg::BNE:  cond = !i_eq;
      rv_isa_pkg::BLT:  cond = i_lt;
      rv_isa_pkg::BGE:  cond = !i_lt;
      rv_isa_pkg::BLTU: cond = i_ltu;
      rv_isa_pkg::BGEU: cond = !i_ltu;
      default:          cond = 1'b0;
    endcase
  end

  assign taken  = i_branch && cond;
  assign pc_inc = taken ? i_br_offset : `RV_XLEN'(`RV_PC_STEP);

  // halt freezes the pc so ecall is presented every cycle after
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc <= `RV_XLEN'(`RV_RESET_PC);
    end else if (!i_halt) begin
      o_pc <= o_pc + pc_inc;
    end
  end

endmodule

// ==== rv_regfile.sv ====
`include "rv_core_params.svh"

module rv_regfile (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [`RV_REG_AW-1:0] i_rs1,
  input  logic [`RV_REG_AW-1:0] i_rs2,
  input  logic [`RV_REG_AW-1:0] i_rd,
  input  logic                  i_we,
  input  logic [`RV_XLEN-1:0]   i_wdata,
  output logic [`RV_XLEN-1:0]   o_rs1_data,
  output logic [`RV_XLEN-1:0]   o_rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 reads as zero whatever the array holds
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== rv_alu.sv ====
`include "rv_core_params.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0]  i_a,
  input  logic [`RV_XLEN-1:0]  i_b,
  input  rv_ctrl_pkg::alu_op_e i_op,
  output logic [`RV_XLEN-1:0]  o_result,
  output logic                 o_eq,
  output logic                 o_lt,
  output logic                 o_ltu
);

  logic [`RV_XLEN:0]   diff;
  logic [4:0]          shamt;
  logic                sign_a;
  logic                sign_b;

  // one subtractor serves sub, the set-less-than ops and the branch flags
  assign diff   = {1'b0, i_a} - {1'b0, i_b};
  assign sign_a = i_a[`RV_XLEN-1];
  assign sign_b = i_b[`RV_XLEN-1];
  assign shamt  = i_b[4:0];

  assign o_eq  = (diff[`RV_XLEN-1:0] == '0);
  // borrow out of the wide subtract
  assign o_ltu = diff[`RV_XLEN];
  // signs differ: a is less when it is negative
  assign o_lt  = (sign_a != sign_b) ? sign_a : diff[`RV_XLEN-1];

  always_comb begin
    case (i_op)
      rv_ctrl_pkg::ADD:  o_result = i_a + i_b;
      rv_ctrl_pkg::SUB:  o_result = diff[`RV_XLEN-1:0];
      rv_ctrl_pkg::SLL:  o_result = i_a << shamt;
      rv_ctrl_pkg::SLT:  o_result = {{(`RV_XLEN-1){1'b0}}, o_lt};
      rv_ctrl_pkg::SLTU: o_result = {{(`RV_XLEN-1){1'b0}}, o_ltu};
      rv_ctrl_pkg::XOR:  o_result = i_a ^ i_b;
      rv_ctrl_pkg::SRL:  o_result = i_a >> shamt;
      rv_ctrl_pkg::SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
      rv_ctrl_pkg::OR:   o_result = i_a | i_b;
      rv_ctrl_pkg::AND:  o_result = i_a & i_b;
      default:           o_result = '0;
    endcase
  end

endmodule

// ==== rv_decoder.sv ====
`include "rv_core_params.svh"

module rv_decoder (
  input  logic [`RV_XLEN-1:0]   i_insn,
  output logic [`RV_REG_AW-1:0] o_rs1,
  output logic [`RV_REG_AW-1:0] o_rs2,
  output logic [`RV_REG_AW-1:0] o_rd,
  output logic [`RV_XLEN-1:0]   o_imm,
  output rv_ctrl_pkg::alu_op_e  o_alu_op,
  output rv_ctrl_pkg::opb_sel_e o_opb_sel,
  output rv_ctrl_pkg::wb_sel_e  o_wb_sel,
  output logic                  o_rf_we,
  output logic                  o_branch,
  output rv_isa_pkg::br_f3_e    o_br_f3,
  output logic                  o_halt
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::alu_f3_e funct3;
  logic [6:0]          funct7;
  logic                alt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;

  // fixed field positions shared by every format
  assign opcode = rv_isa_pkg::opcode_e'(i_insn[6:0]);
  assign funct3 = rv_isa_pkg::alu_f3_e'(i_insn[14:12]);
  assign funct7 = i_insn[31:25];
  assign alt    = (funct7 == rv_isa_pkg::F7_ALT);
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // immediates, sign bit is always insn[31]
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  assign o_br_f3 = rv_isa_pkg::br_f3_e'(i_insn[14:12]);

  always_comb begin
    o_imm     = imm_i;
    o_alu_op  = rv_ctrl_pkg::SUB;
    o_opb_sel = rv_ctrl_pkg::OPB_REG;
    o_wb_sel  = rv_ctrl_pkg::WB_ALU;
    o_rf_we   = 1'b0;
    o_branch  = 1'b0;
    o_halt    = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        o_imm    = imm_u;
        o_wb_sel = rv_ctrl_pkg::WB_UIMM;
        o_rf_we  = 1'b1;
      end
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG: begin
        o_rf_we = 1'b1;
        if (opcode == rv_isa_pkg::OP_IMM) begin
          o_opb_sel = rv_ctrl_pkg::OPB_IMM;
        end
        case (funct3)
          // only the register form has sub
          rv_isa_pkg::ADD: begin
            o_alu_op = (opcode == rv_isa_pkg::OP_REG && alt) ? rv_ctrl_pkg::SUB
                                                             : rv_ctrl_pkg::ADD;
          end
          rv_isa_pkg::SLL:  o_alu_op = rv_ctrl_pkg::SLL;
          rv_isa_pkg::SLT:  o_alu_op = rv_ctrl_pkg::SLT;
          rv_isa_pkg::SLTU: o_alu_op = rv_ctrl_pkg::SLTU;
          rv_isa_pkg::XOR:  o_alu_op = rv_ctrl_pkg::XOR;
          rv_isa_pkg::SR:   o_alu_op = alt ? rv_ctrl_pkg::SRA : rv_ctrl_pkg::SRL;
          rv_isa_pkg::OR:   o_alu_op = rv_ctrl_pkg::OR;
          default:          o_alu_op = rv_ctrl_pkg::AND;
        endcase
      end
      rv_isa_pkg::OP_BRANCH: begin
        // compare flags come from the alu subtractor, rs2 as operand b
        o_imm    = imm_b;
        o_branch = 1'b1;
      end
      rv_isa_pkg::OP_SYSTEM: begin
        // ecall is the all-zero system encoding
        o_halt = (i_insn[31:7] == '0);
      end
      default: ;
    endcase
  end

endmodule

// ==== rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

  // operations the alu can perform
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_e;

  // second alu operand source
  typedef enum logic {
    OPB_REG,
    OPB_IMM
  } opb_sel_e;

  // register write-back source
  typedef enum logic {
    WB_ALU,
    WB_UIMM
  } wb_sel_e;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for the register-immediate and register-register groups
  typedef enum logic [2:0] {
    ADD  = 3'b000,
    SLL  = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SR   = 3'b101,
    OR   = 3'b110,
    AND  = 3'b111
  } alu_f3_e;

  // funct3 for conditional branches, 010 and 011 are not used
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_f3_e;

  // funct7 values
  localparam logic [6:0] F7_BASE = 7'b0000000;
  // picks sub over add and sra over srl
  localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// ==== rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data path and program counter width
`define RV_XLEN 32

// architectural register count and index width
`define RV_NREGS 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 0

// byte increment for a sequential instruction
`define RV_PC_STEP 4

`endif
